/* list.f */
+incdir+test
verilog/rv_pkg.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
test/core_chk.sv
test/core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module core_tb -o core_sim
# the simulator exits nonzero on a failed check, the log decides
./obj_dir/core_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Testbench passed" sim.log; then
	exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

/* test/rv_ref.svh */
// instruction-set model of the rv32i subset, included inside core_tb
// expects xfer_t, imem, ref_mem, halt_pc and exp_q in the including module
// only aligned accesses inside the 1 KB data region are modelled
`ifndef RV_REF_SVH
`define RV_REF_SVH

// byte strobe to bit mask
function automatic word_t strb_mask(input logic [3:0] s);
	return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
endfunction

function automatic void push_xfer(input logic d, input word_t a, input logic w,
	input logic [3:0] s, input word_t v);
	xfer_t t;
	t.is_data = d;
	t.addr = a;
	t.write = w;
	t.strb = s;
	t.data = v;
	exp_q.push_back(t);
endfunction

// runs the program until the halt address has been fetched twice
function automatic void ref_run();
	word_t x [32];
	word_t pc, ins, a, b, res, nxt, ea, w, sh;
	word_t ii, is, ib, iu, ij;
	logic [6:0] opc;
	logic [2:0] f3;
	logic [3:0] st;
	logic [7:0] by;
	logic [15:0] hw;
	logic wr, take;
	int halts, steps;
	for (int i = 0; i < 32; i++) begin
		x[i] = '0;
	end
	pc = reset_pc;
	halts = 0;
	steps = 0;
	while (steps < 4000) begin
		steps++;
		push_xfer(1'b0, pc, 1'b0, 4'b0000, '0);
		if (pc == halt_pc) begin
			halts++;
			if (halts == 2) begin
				break;
			end
		end
		ins = imem[pc[9:2]];
		opc = ins[6:0];
		f3 = ins[14:12];
		a = x[ins[19:15]];
		b = x[ins[24:20]];
		ii = {{20{ins[31]}}, ins[31:20]};
		is = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		ib = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		iu = {ins[31:12], 12'h000};
		ij = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		nxt = pc + 32'd4;
		wr = 1'b1;
		res = '0;
		case (opc)
			LUI: res = iu;
			AUIPC: res = pc + iu;
			JAL: begin
				res = pc + 32'd4;
				nxt = pc + ij;
			end
			JALR: begin
				res = pc + 32'd4;
				nxt = (a + ii) & ~32'd1;
			end
			BRANCH: begin
				wr = 1'b0;
				case (f3)
					3'd0: take = (a == b);
					3'd1: take = (a != b);
					3'd4: take = $signed(a) < $signed(b);
					3'd5: take = $signed(a) >= $signed(b);
					3'd6: take = a < b;
					default: take = a >= b;
				endcase
				if (take) begin
					nxt = pc + ib;
				end
			end
			LOAD: begin
				ea = a + ii;
				w = ref_mem[ea[9:2]];
				push_xfer(1'b1, {ea[31:2], 2'b00}, 1'b0, 4'b1111, '0);
				sh = w >> {ea[1:0], 3'b000};
				by = sh[7:0];
				hw = sh[15:0];
				case (f3)
					3'd0: res = {{24{by[7]}}, by};
					3'd1: res = {{16{hw[15]}}, hw};
					3'd4: res = {24'h0, by};
					3'd5: res = {16'h0, hw};
					default: res = w;
				endcase
			end
			STORE: begin
				wr = 1'b0;
				ea = a + is;
				case (f3)
					3'd0: st = 4'b0001 << ea[1:0];
					3'd1: st = 4'b0011 << ea[1:0];
					default: st = 4'b1111;
				endcase
				// rs2 low bits moved up to the addressed lane
				sh = (b << {ea[1:0], 3'b000}) & strb_mask(st);
				w = ref_mem[ea[9:2]];
				ref_mem[ea[9:2]] = (w & ~strb_mask(st)) | sh;
				push_xfer(1'b1, {ea[31:2], 2'b00}, 1'b1, st, sh);
			end
			OP, OP_IMM: begin
				if (opc == OP_IMM) begin
					b = ii;
				end
				case (f3)
					3'd0: res = (opc == OP && ins[30]) ? a - b : a + b;
					3'd2: res = {31'b0, $signed(a) < $signed(b)};
					3'd3: res = {31'b0, a < b};
					3'd4: res = a ^ b;
					3'd6: res = a | b;
					3'd7: res = a & b;
					default: wr = 1'b0;
				endcase
			end
			default: wr = 1'b0;
		endcase
		if (wr && ins[11:7] != 5'd0) begin
			x[ins[11:7]] = res;
		end
		pc = nxt;
	end
endfunction

`endif

/* test/core_tb.sv */
// random program testbench for rv_core
// program at reset_pc, 1 KB data region at 0x8000_1000, both 256 words
// compares every bus transfer in order with the included isa model
module core_tb import rv_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int max_stall = 12;

	// one expected bus transfer
	typedef struct packed {
		logic is_data;
		word_t addr;
		logic write;
		logic [3:0] strb;
		word_t data;
	} xfer_t;

	logic clock;
	logic reset;
	word_t iaddr;
	logic ivalid;
	word_t idata;
	logic iready;
	dbus_req_t dreq;
	logic dvalid;
	word_t drdata;
	logic dready;

	word_t imem [256];
	word_t dmem [256];
	word_t ref_mem [256];
	word_t halt_pc;
	xfer_t exp_q [$];
	xfer_t exp_e;
	word_t rng;
	word_t ioff;
	logic ref_done;
	int n_instr;
	int irun;
	int drun;

	`include "rv_ref.svh"

	rv_core u_dut (
		.clock(clock),
		.reset(reset),
		.iaddr(iaddr),
		.ivalid(ivalid),
		.idata(idata),
		.iready(iready),
		.dreq(dreq),
		.dvalid(dvalid),
		.drdata(drdata),
		.dready(dready)
	);

	always #4 clock = !clock;

	// memories answer combinationally
	assign ioff = iaddr - reset_pc;
	assign idata = imem[ioff[9:2]];
	assign drdata = dmem[dreq.addr[9:2]];

	function automatic word_t xorshift(input word_t s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	function word_t next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// instruction encoders
	function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
		input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_r(input logic f7b, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {1'b0, f7b, 5'b0, rs2, rs1, f3, rd, OP};
	endfunction

	function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
	endfunction

	function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
	endfunction

	function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
	endfunction

	function void emit(input word_t w);
		imem[n_instr] = w;
		n_instr++;
	endfunction

	// random working register, x1..x15
	function reg_addr_t pick_reg();
		word_t r;
		r = next_rand();
		return reg_addr_t'(1 + r % 15);
	endfunction

	// alu funct3 values without the shifts
	function logic [2:0] pick_alu_f3();
		word_t r;
		r = next_rand();
		case (r % 6)
			0: return 3'd0;
			1: return 3'd2;
			2: return 3'd3;
			3: return 3'd4;
			4: return 3'd6;
			default: return 3'd7;
		endcase
	endfunction

	function void build_program();
		word_t r;
		word_t r2;
		logic [1:0] sz;
		logic [11:0] off;
		logic [2:0] f3;
		n_instr = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
		end
		// x31 holds the data base
		emit({20'h80001, 5'd31, LUI});
		// every working register starts from a random value
		for (int i = 1; i < 16; i++) begin
			r = next_rand();
			emit({r[31:12], reg_addr_t'(i), LUI});
			emit(enc_i(r[11:0], reg_addr_t'(i), 3'd0, reg_addr_t'(i), OP_IMM));
		end
		repeat (60) begin
			r = next_rand();
			r2 = next_rand();
			sz = (r[7:4] % 3 == 0) ? 2'd0 : ((r[7:4] % 3 == 1) ? 2'd1 : 2'd2);
			off = {5'b0, r2[6:0]} & ~((12'd1 << sz) - 12'd1);
			case (r % 10)
				0: emit(enc_r(r[8], pick_reg(), pick_reg(), pick_alu_f3(), pick_reg()));
				1: emit(enc_i(r2[11:0], pick_reg(), pick_alu_f3(), pick_reg(), OP_IMM));
				2: emit({r2[31:12], pick_reg(), r[9] ? LUI : AUIPC});
				3, 4, 9: emit(enc_s(off, pick_reg(), 5'd31, {1'b0, sz}));
				5: begin
					// no lwu
					f3 = {r[10] && sz != 2'd2, sz};
					emit(enc_i(off, 5'd31, f3, pick_reg(), LOAD));
				end
				6: begin
					// forward over one filler, or to the next instruction
					f3 = pick_alu_f3();
					f3 = (f3 == 3'd2) ? 3'd1 : ((f3 == 3'd3) ? 3'd5 : f3);
					emit(enc_b(r[11] ? 13'd8 : 13'd4, pick_reg(), pick_reg(), f3));
					emit(enc_i(r2[11:0], pick_reg(), 3'd0, pick_reg(), OP_IMM));
				end
				7: begin
					emit(enc_j(21'd8, pick_reg()));
					emit(enc_i(r2[11:0], pick_reg(), 3'd4, pick_reg(), OP_IMM));
				end
				default: begin
					// auipc x9 then jalr past the filler
					emit({20'h0, 5'd9, AUIPC});
					emit(enc_i(12'd12, 5'd9, 3'd0, pick_reg(), JALR));
					emit(enc_i(r2[11:0], pick_reg(), 3'd6, pick_reg(), OP_IMM));
				end
			endcase
		end
		// dump the working registers
		for (int i = 1; i < 16; i++) begin
			emit(enc_s(12'(64 + 4 * i), reg_addr_t'(i), 5'd31, 3'd2));
		end
		halt_pc = reset_pc + word_t'(4 * n_instr);
		emit(enc_j(21'd0, 5'd0));
	endfunction

	task check(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		iready = 1'b0;
		dready = 1'b0;
		ref_done = 1'b0;
		irun = 0;
		drun = 0;
		rng = 32'd26;
		for (int i = 0; i < 256; i++) begin
			dmem[i] = next_rand();
			ref_mem[i] = dmem[i];
		end
		build_program();
		ref_run();
		ref_done = 1'b1;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

	// ready stalls, with occasional long runs of low ready
	always @(negedge clock) begin
		if (!reset) begin
			if (irun > 0) begin
				irun <= irun - 1;
				iready <= 1'b0;
			end else begin
				iready <= next_rand() % 3 != 0;
				if (rng[9:6] == 4'd0) begin
					irun <= int'(rng[15:12] % max_stall);
				end
			end
			if (drun > 0) begin
				drun <= drun - 1;
				dready <= 1'b0;
			end else begin
				dready <= next_rand() % 3 != 0;
				if (rng[9:6] == 4'd0) begin
					drun <= int'(rng[15:12] % max_stall);
				end
			end
		end
	end

	// in-order transfer comparison
	always @(posedge clock) begin
		if (!reset && ((ivalid && iready) || (dvalid && dready))) begin
			if (exp_q.size() == 0) begin
				$display("bus transfer after the end of the expected sequence");
				$display("Testbench failed");
				$fatal(1);
			end
			exp_e = exp_q.pop_front();
			check("transfer is data", {31'b0, dvalid}, {31'b0, exp_e.is_data});
			if (ivalid) begin
				check("fetch address", iaddr, exp_e.addr);
			end else begin
				check("data address", dreq.addr, exp_e.addr);
				check("data write", {31'b0, dreq.write}, {31'b0, exp_e.write});
				check("data strobe", {28'b0, dreq.strb}, {28'b0, exp_e.strb});
				check("store data", dreq.wdata & strb_mask(dreq.strb) &
					{32{dreq.write}}, exp_e.data);
				if (dreq.write) begin
					dmem[dreq.addr[9:2]] <= (dmem[dreq.addr[9:2]] & ~strb_mask(dreq.strb)) |
						(dreq.wdata & strb_mask(dreq.strb));
				end
			end
			// second halt fetch closes the run
			if (exp_q.size() == 0) begin
				$display("Testbench passed");
				$finish;
			end
		end
	end

	// watchdog
	initial begin
		wait (ref_done);
		repeat (exp_q.size() * 20 * max_stall) @(posedge clock);
		$display("timeout: the core stopped making the expected bus transfers");
		$display("Testbench failed");
		$fatal(1);
	end

endmodule

/* test/core_chk.sv */
// bus protocol and register write checks for rv_core
// attached to every rv_core instance by bind
module core_chk import rv_pkg::*; (
	input logic clock,
	input logic reset,
	input word_t iaddr,
	input logic ivalid,
	input logic iready,
	input dbus_req_t dreq,
	input logic dvalid,
	input logic dready,
	input logic rd_wen,
	input reg_addr_t rd_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	// held request stays put until accepted
	a_ibus_hold: assert property (@(posedge clock) disable iff (reset)
		ivalid && !iready |=> ivalid && $stable(iaddr))
		else $error("instruction request dropped or changed before iready");
	a_dbus_hold: assert property (@(posedge clock) disable iff (reset)
		dvalid && !dready |=> dvalid && $stable(dreq))
		else $error("data request dropped or changed before dready");

	// one bus at a time
	a_one_bus: assert property (@(posedge clock) disable iff (reset)
		!(ivalid && dvalid))
		else $error("ivalid and dvalid high together");

	a_no_x0: assert property (@(posedge clock) disable iff (reset)
		!(rd_wen && rd_addr == '0))
		else $error("register write to x0");

	a_reset_idle: assert property (@(posedge clock) reset |=> !dvalid)
		else $error("dvalid high after reset");

endmodule

bind rv_core core_chk u_chk (
	.clock(clock),
	.reset(reset),
	.iaddr(iaddr),
	.ivalid(ivalid),
	.iready(iready),
	.dreq(dreq),
	.dvalid(dvalid),
	.dready(dready),
	.rd_wen(rd_wen),
	.rd_addr(dec_q.rd)
);

/* verilog/rv_core.sv */
// multi-cycle rv32i core, one instruction in flight
// fetch, decode, execute always; mem only for loads and stores
// no traps: misaligned accesses and unknown opcodes are not detected
// both buses hold valid and payload until ready
module rv_core import rv_pkg::*; (
	input  logic clock,
	input  logic reset,
	output word_t iaddr,
	output logic ivalid,
	input  word_t idata,
	input  logic iready,
	output dbus_req_t dreq,
	output logic dvalid,
	input  word_t drdata,
	input  logic dready
);

	state_t state;
	word_t pc;
	word_t instr;
	decoded_t dec_w;
	decoded_t dec_q;

	word_t ra_data;
	word_t rb_data;
	word_t op_a;
	word_t op_b;
	word_t alu_result;
	logic cmp_out;

	word_t pc_plus4;
	word_t branch_target;
	logic branch_taken;
	word_t pc_next;

	word_t rd_data;
	logic rd_wen;
	logic mem_op;
	logic lsu_start;
	word_t load_data;
	logic lsu_done;

	assign iaddr = pc;
	assign ivalid = (state == FETCH);

	// instruction register feeds the decoder
	rv_decode u_decode (
		.instr(instr),
		.dec(dec_w)
	);

	always_ff @(posedge clock) begin
		if (ivalid && iready) begin
			instr <= idata;
		end
		if (state == DECODE) begin
			dec_q <= dec_w;
		end
	end

	rv_regfile u_regfile (
		.clock(clock),
		.ra_addr(dec_q.rs1),
		.ra_data(ra_data),
		.rb_addr(dec_q.rs2),
		.rb_data(rb_data),
		.rd_addr(dec_q.rd),
		.rd_data(rd_data),
		.rd_wen(rd_wen)
	);

	// operand select; lui adds its immediate to zero
	assign op_a = dec_q.is_lui ? '0 : ((dec_q.opnd_a == OPA_PC) ? pc : ra_data);
	assign op_b = (dec_q.opnd_b == OPB_IMM) ? dec_q.imm : rb_data;

	rv_alu u_alu (
		.op_a(op_a),
		.op_b(op_b),
		.op(dec_q.alu_op),
		.cmp(dec_q.cmp_op),
		.result(alu_result),
		.cmp_out(cmp_out)
	);

	// branch operands are rs1/rs2, so the target needs its own adder
	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc + dec_q.imm;
	assign branch_taken = dec_q.is_branch && (cmp_out ^ dec_q.branch_invert);

	always_comb begin
		if (dec_q.is_jalr) begin
			pc_next = {alu_result[31:1], 1'b0};
		end else if (dec_q.is_jal) begin
			pc_next = alu_result;
		end else if (branch_taken) begin
			pc_next = branch_target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	assign mem_op = dec_q.is_load || dec_q.is_store;
	assign lsu_start = (state == EXECUTE) && mem_op;

	rv_lsu u_lsu (
		.clock(clock),
		.reset(reset),
		.start(lsu_start),
		.addr(alu_result),
		.store_data(rb_data),
		.size(dec_q.size),
		.is_store(dec_q.is_store),
		.load_unsigned(dec_q.load_unsigned),
		.dreq(dreq),
		.dvalid(dvalid),
		.drdata(drdata),
		.dready(dready),
		.load_data(load_data),
		.done(lsu_done)
	);

	// write-back source
	always_comb begin
		if (state == MEM) begin
			rd_data = load_data;
		end else if (dec_q.is_jal || dec_q.is_jalr) begin
			rd_data = pc_plus4;
		end else if (dec_q.is_slt) begin
			rd_data = {31'b0, cmp_out};
		end else begin
			rd_data = alu_result;
		end
	end

	// loads write in the bus transfer cycle, the rest at the end of execute
	assign rd_wen = dec_q.writes_rd &&
		(((state == EXECUTE) && !dec_q.is_load) ||
		((state == MEM) && dec_q.is_load && lsu_done));

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FETCH;
			pc <= reset_pc;
		end else begin
			case (state)
				FETCH: begin
					if (iready) begin
						state <= DECODE;
					end
				end
				DECODE: state <= EXECUTE;
				EXECUTE: begin
					// pc no longer needed once the access is issued
					pc <= pc_next;
					state <= mem_op ? MEM : FETCH;
				end
				default: begin
					if (lsu_done) begin
						state <= FETCH;
					end
				end
			endcase
		end
	end

endmodule

/* verilog/rv_lsu.sv */
// load/store unit for the valid/ready data bus
// one request per start pulse; start must not come while dvalid is high
// address must be aligned to the access size
module rv_lsu import rv_pkg::*; (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  word_t addr,
	input  word_t store_data,
	input  size_t size,
	input  logic is_store,
	input  logic load_unsigned,
	output dbus_req_t dreq,
	output logic dvalid,
	input  word_t drdata,
	input  logic dready,
	output word_t load_data,
	output logic done
);

	word_t lane_data;
	logic [3:0] lane_strb;
	logic [1:0] lane_q;
	size_t size_q;
	logic unsigned_q;
	logic [7:0] byte_sel;
	logic [15:0] half_sel;

	// replicate store data across lanes, strobe picks the live ones
	always_comb begin
		case (size)
			BYTE: begin
				lane_data = {4{store_data[7:0]}};
				lane_strb = 4'b0001 << addr[1:0];
			end
			HALF: begin
				lane_data = {2{store_data[15:0]}};
				lane_strb = addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				lane_data = store_data;
				lane_strb = 4'b1111;
			end
		endcase
	end

	// request payload, captured once per access
	always_ff @(posedge clock) begin
		if (start) begin
			dreq.addr <= {addr[31:2], 2'b00};
			dreq.wdata <= lane_data;
			// loads always ask for the full word
			dreq.strb <= is_store ? lane_strb : 4'b1111;
			dreq.write <= is_store;
			lane_q <= addr[1:0];
			size_q <= size;
			unsigned_q <= load_unsigned;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			dvalid <= 1'b0;
		end else if (start) begin
			dvalid <= 1'b1;
		end else if (dready) begin
			dvalid <= 1'b0;
		end
	end

	assign done = dvalid && dready;

	// pick the addressed lane of the returned word
	assign byte_sel = drdata[{lane_q, 3'b000} +: 8];
	assign half_sel = lane_q[1] ? drdata[31:16] : drdata[15:0];

	always_comb begin
		case (size_q)
			BYTE: load_data = {{24{!unsigned_q && byte_sel[7]}}, byte_sel};
			HALF: load_data = {{16{!unsigned_q && half_sel[15]}}, half_sel};
			default: load_data = drdata;
		endcase
	end

endmodule

/* verilog/rv_decode.sv */
// combinational rv32i decoder
// unsupported opcodes and funct3 values give a record with no side effects
// sltiu and the logical immediates use the sign-extended I immediate
module rv_decode import rv_pkg::*; (
	input  word_t instr,
	output decoded_t dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];

	// immediate formats
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		dec = '0;
		dec.rs1 = instr[19:15];
		dec.rs2 = instr[24:20];
		dec.rd = instr[11:7];
		dec.imm = imm_i;
		dec.alu_op = ADD;
		dec.cmp_op = EQ;
		dec.opnd_a = OPA_REG;
		dec.opnd_b = OPB_REG;
		dec.size = WORD;
		case (opcode)
			LOAD: begin
				// lb lh lw lbu lhu only
				dec.is_load = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
				dec.writes_rd = dec.is_load;
				dec.opnd_b = OPB_IMM;
				dec.size = size_t'(funct3[1:0]);
				dec.load_unsigned = funct3[2];
			end
			STORE: begin
				dec.is_store = !funct3[2] && (funct3[1:0] != 2'b11);
				dec.imm = imm_s;
				dec.opnd_b = OPB_IMM;
				dec.size = size_t'(funct3[1:0]);
			end
			OP_IMM, OP: begin
				dec.opnd_b = (opcode == OP_IMM) ? OPB_IMM : OPB_REG;
				dec.writes_rd = 1'b1;
				case (funct3)
					3'b000: dec.alu_op = (opcode == OP && instr[30]) ? SUB : ADD;
					3'b010: begin
						dec.is_slt = 1'b1;
						dec.cmp_op = LT;
					end
					3'b011: begin
						dec.is_slt = 1'b1;
						dec.cmp_op = LTU;
					end
					3'b100: dec.alu_op = XOR;
					3'b110: dec.alu_op = OR;
					3'b111: dec.alu_op = AND;
					// shifts are not implemented
					default: dec.writes_rd = 1'b0;
				endcase
			end
			BRANCH: begin
				// alu compares rs1 and rs2, the core adds pc and imm
				dec.is_branch = (funct3[2:1] != 2'b01);
				dec.imm = imm_b;
				dec.cmp_op = !funct3[2] ? EQ : (funct3[1] ? LTU : LT);
				dec.branch_invert = funct3[0];
			end
			JAL: begin
				dec.is_jal = 1'b1;
				dec.writes_rd = 1'b1;
				dec.imm = imm_j;
				dec.opnd_a = OPA_PC;
				dec.opnd_b = OPB_IMM;
			end
			JALR: begin
				dec.is_jalr = 1'b1;
				dec.writes_rd = 1'b1;
				dec.opnd_b = OPB_IMM;
			end
			LUI, AUIPC: begin
				dec.is_lui = (opcode == LUI);
				dec.writes_rd = 1'b1;
				dec.imm = imm_u;
				dec.opnd_a = OPA_PC;
				dec.opnd_b = OPB_IMM;
			end
			default: ;
		endcase
		// x0 is never a destination
		if (dec.rd == '0) begin
			dec.writes_rd = 1'b0;
		end
	end

endmodule

/* verilog/rv_regfile.sv */
// 32 x 32 integer register file
// two asynchronous read ports, one synchronous write port
// x0 reads as zero, a read of the register being written sees the old value
module rv_regfile import rv_pkg::*; (
	input  logic clock,
	input  reg_addr_t ra_addr,
	output word_t ra_data,
	input  reg_addr_t rb_addr,
	output word_t rb_data,
	input  reg_addr_t rd_addr,
	input  word_t rd_data,
	input  logic rd_wen
);

	// entry 0 is never written
	word_t regs [32];

	always_ff @(posedge clock) begin
		if (rd_wen && rd_addr != '0) begin
			regs[rd_addr] <= rd_data;
		end
	end

	// x0 forced to zero on read
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

/* verilog/rv_alu.sv */
// combinational alu and comparator
// the comparator always looks at op_a and op_b, independent of op
// branch polarity is handled by the caller
module rv_alu import rv_pkg::*; (
	input  word_t op_a,
	input  word_t op_b,
	input  alu_op_t op,
	input  cmp_op_t cmp,
	output word_t result,
	output logic cmp_out
);

	logic a_lt_b;
	logic a_ltu_b;

	// signed and unsigned less-than
	assign a_lt_b = $signed(op_a) < $signed(op_b);
	assign a_ltu_b = op_a < op_b;

	always_comb begin
		case (op)
			ADD: result = op_a + op_b;
			SUB: result = op_a - op_b;
			XOR: result = op_a ^ op_b;
			OR: result = op_a | op_b;
			AND: result = op_a & op_b;
			// unused encodings
			default: result = op_a + op_b;
		endcase
	end

	always_comb begin
		case (cmp)
			// beq, bne
			EQ: cmp_out = (op_a == op_b);
			// blt, bge, slt
			LT: cmp_out = a_lt_b;
			// bltu, bgeu, sltu
			LTU: cmp_out = a_ltu_b;
			default: cmp_out = 1'b0;
		endcase
	end

endmodule

/* verilog/rv_pkg.sv */
// shared types for the multi-cycle rv32i core
// no csr, shift, fence or system support; those opcodes decode as no-ops
// data bus is word addressed with byte strobes, accesses must be aligned
package rv_pkg;

	localparam int xlen = 32;
	localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

	typedef logic [4:0] reg_addr_t;
	typedef logic [xlen-1:0] word_t;

	// base opcodes, instr[6:0]
	localparam logic [6:0] LOAD   = 7'b0000011;
	localparam logic [6:0] STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP     = 7'b0110011;
	localparam logic [6:0] BRANCH = 7'b1100011;
	localparam logic [6:0] JAL    = 7'b1101111;
	localparam logic [6:0] JALR   = 7'b1100111;
	localparam logic [6:0] LUI    = 7'b0110111;
	localparam logic [6:0] AUIPC  = 7'b0010111;

	typedef enum logic [1:0] {FETCH, DECODE, EXECUTE, MEM} state_t;

	typedef enum logic [2:0] {ADD, SUB, XOR, OR, AND} alu_op_t;

	typedef enum logic [1:0] {EQ, LT, LTU} cmp_op_t;

	// encoding follows funct3[1:0] of loads and stores
	typedef enum logic [1:0] {BYTE, HALF, WORD} size_t;

	typedef enum logic {OPA_REG, OPA_PC} opnd_a_t;
	typedef enum logic {OPB_REG, OPB_IMM} opnd_b_t;

	// one decoded instruction, held through execute and mem
	typedef struct packed {
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t imm;
		alu_op_t alu_op;
		cmp_op_t cmp_op;
		opnd_a_t opnd_a;
		opnd_b_t opnd_b;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic is_jal;
		logic is_jalr;
		logic is_lui;
		logic is_slt;
		logic branch_invert;
		logic load_unsigned;
		size_t size;
		// cleared for rd == x0
		logic writes_rd;
	} decoded_t;

	// data bus request, 69 bits
	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic [3:0] strb;
		logic write;
	} dbus_req_t;

endpackage
